//--- sources.f
+incdir+rtl
rtl/vlsu_pkg.sv
rtl/axi_addr_pkg.sv
rtl/addrgen_req_check.sv
rtl/addrgen_burst_split.sv
rtl/addrgen_top.sv
sim/tb_clk_gen.sv
sim/tb_addrgen.sv

//--- Bender.yml
package:
  name: vector_addrgen

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vlsu_pkg.sv
      - rtl/axi_addr_pkg.sv
      - rtl/addrgen_req_check.sv
      - rtl/addrgen_burst_split.sv
      - rtl/addrgen_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_addrgen.sv

//--- sim/tb_addrgen.sv
// Testbench of the vector address generator, directed and random requests against a reference model
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module tb_addrgen;

  localparam int WAIT_LIMIT = 20000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_valid_i;
  logic                   req_ready_o;
  logic                   ack_o;
  logic                   error_o;
  vlsu_pkg::mem_op_e      req_op_i;
  vlsu_pkg::addr_t        req_addr_i;
  vlsu_pkg::vlen_t        req_len_i;
  vlsu_pkg::stride_t      req_stride_i;
  vlsu_pkg::vew_e         req_vew_i;
  logic                   ar_valid_o;
  logic                   ar_ready_i;
  vlsu_pkg::addr_t        ar_addr_o;
  axi_addr_pkg::ax_len_t  ar_len_o;
  axi_addr_pkg::ax_size_t ar_size_o;
  logic                   aw_valid_o;
  logic                   aw_ready_i;
  vlsu_pkg::addr_t        aw_addr_o;
  axi_addr_pkg::ax_len_t  aw_len_o;
  axi_addr_pkg::ax_size_t aw_size_o;

  // Expected bus requests in order, tagged with their request
  int              exp_id_q[$];
  bit              exp_store_q[$];
  vlsu_pkg::addr_t exp_addr_q[$];
  int              exp_len_q[$];
  int              exp_size_q[$];
  // Expected acks in acceptance order
  int              ack_id_q[$];
  bit              ack_err_q[$];

  int          value_errors = 0;
  int          order_errors = 0;
  int          timeouts = 0;
  int          beats_seen = 0;
  int          next_id = 0;
  logic        stall_en = 1'b0;
  logic [15:0] stim_lfsr = 16'd11355;
  logic [15:0] stall_lfsr = 16'd11355;
  logic        ar_wait = 1'b0;
  logic        aw_wait = 1'b0;
  logic [42:0] ar_prev;
  logic [42:0] aw_prev;

  tb_clk_gen clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  addrgen_top uut (.*);

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // n stimulus bits, one LFSR step per bit
  function automatic int unsigned stim_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | stim_lfsr[0];
      stim_lfsr = lfsr_step(stim_lfsr);
    end
    return v;
  endfunction

  function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endfunction

  function automatic void report_fault(string what);
    order_errors++;
    $display("at %0t: %s", $time, what);
  endfunction

  function automatic void push_beat(int id, bit store, vlsu_pkg::addr_t addr, int len,
                                    int size);
    exp_id_q.push_back(id);
    exp_store_q.push_back(store);
    exp_addr_q.push_back(addr);
    exp_len_q.push_back(len);
    exp_size_q.push_back(size);
  endfunction

  // Reference model, queues the bus requests of one request and returns its error flag
  function automatic bit expect_request(int id, vlsu_pkg::mem_op_e op, vlsu_pkg::addr_t addr,
                                        int len, vlsu_pkg::stride_t stride, int ew_log);
    vlsu_pkg::addr_t cur;
    vlsu_pkg::addr_t last;
    vlsu_pkg::addr_t word_last;
    vlsu_pkg::addr_t page_last;
    int              rem;
    int              elems;
    bit              store;
    bit              unit;
    store = (op == vlsu_pkg::OP_STORE_UNIT) || (op == vlsu_pkg::OP_STORE_STRIDED);
    unit  = (op == vlsu_pkg::OP_LOAD_UNIT) || (op == vlsu_pkg::OP_STORE_UNIT);
    if ((addr % (1 << ew_log)) != 0) begin
      return 1'b1;
    end
    cur = addr;
    rem = len;
    while (rem > 0) begin
      if (unit) begin
        // Burst ends at the earliest of transfer end, 256th word and page end
        last      = cur + rem * (1 << ew_log) - 1;
        word_last = cur - (cur % `DATA_BYTES) + `MAX_BURST_BEATS * `DATA_BYTES - 1;
        page_last = cur - (cur % (1 << `PAGE_BITS)) + (1 << `PAGE_BITS) - 1;
        if (word_last < last) last = word_last;
        if (page_last < last) last = page_last;
        push_beat(id, store, cur, last / `DATA_BYTES - cur / `DATA_BYTES, `DATA_BYTES_LOG);
        elems = (last - cur + 1) / (1 << ew_log);
        rem   = (rem > elems) ? rem - elems : 0;
        cur   = (last / `DATA_BYTES + 1) * `DATA_BYTES;
      end else begin
        push_beat(id, store, cur, 0, ew_log);
        cur = cur + stride;
        rem = rem - 1;
      end
    end
    return 1'b0;
  endfunction

  ////////////////////
  // Compare
  ////////////////////

  function automatic void check_beat(bit store, vlsu_pkg::addr_t addr, int len, int size);
    string ch;
    ch = store ? "aw" : "ar";
    beats_seen++;
    if (exp_id_q.size() == 0) begin
      report_fault({"bus request on ", ch, " with none expected"});
      return;
    end
    if (exp_store_q[0] != store) report_fault({"bus request on ", ch, " is on the wrong channel"});
    check_value({ch, "_addr_o"}, addr, exp_addr_q[0]);
    check_value({ch, "_len_o"}, len, exp_len_q[0]);
    check_value({ch, "_size_o"}, size, exp_size_q[0]);
    void'(exp_id_q.pop_front());
    void'(exp_store_q.pop_front());
    void'(exp_addr_q.pop_front());
    void'(exp_len_q.pop_front());
    void'(exp_size_q.pop_front());
  endfunction

  function automatic void check_ack();
    int id;
    if (ack_id_q.size() == 0) begin
      report_fault("ack_o with no request outstanding");
      return;
    end
    id = ack_id_q.pop_front();
    check_value("error_o", error_o, ack_err_q.pop_front());
    // All bus requests of this request must be out first
    if (exp_id_q.size() != 0 && exp_id_q[0] == id) begin
      report_fault("ack_o before the last bus request of its request");
    end
  endfunction

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (req_valid_i && req_ready_o) begin
        ack_err_q.push_back(expect_request(next_id, req_op_i, req_addr_i, req_len_i,
                                           req_stride_i, req_vew_i));
        ack_id_q.push_back(next_id);
        next_id++;
      end
      if (ar_valid_o && aw_valid_o) report_fault("AR and AW valid in the same cycle");
      // Payload must hold from a stalled edge to the next
      if (ar_wait && (!ar_valid_o || {ar_addr_o, ar_len_o, ar_size_o} !== ar_prev)) begin
        report_fault("AR request dropped or changed while waiting for ready");
      end
      if (aw_wait && (!aw_valid_o || {aw_addr_o, aw_len_o, aw_size_o} !== aw_prev)) begin
        report_fault("AW request dropped or changed while waiting for ready");
      end
      ar_wait = ar_valid_o && !ar_ready_i;
      aw_wait = aw_valid_o && !aw_ready_i;
      ar_prev = {ar_addr_o, ar_len_o, ar_size_o};
      aw_prev = {aw_addr_o, aw_len_o, aw_size_o};
      if (ar_valid_o && ar_ready_i) check_beat(1'b0, ar_addr_o, ar_len_o, ar_size_o);
      if (aw_valid_o && aw_ready_i) check_beat(1'b1, aw_addr_o, aw_len_o, aw_size_o);
      if (error_o && !ack_o) report_fault("error_o high without ack_o");
      if (ack_o) check_ack();
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Ready stalls from their own LFSR, two bits per cycle
  initial begin
    ar_ready_i = 1'b1;
    aw_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      ar_ready_i <= !stall_en || stall_lfsr[0];
      stall_lfsr = lfsr_step(stall_lfsr);
      aw_ready_i <= !stall_en || stall_lfsr[0];
      stall_lfsr = lfsr_step(stall_lfsr);
    end
  end

  // Called just after a rising edge, returns on the accepting edge
  task automatic send_request(input vlsu_pkg::mem_op_e op, input vlsu_pkg::addr_t addr,
                              input int len, input vlsu_pkg::stride_t stride,
                              input vlsu_pkg::vew_e vew);
    int waited;
    waited = 0;
    if (timeouts == 0) begin
      req_valid_i  <= 1'b1;
      req_op_i     <= op;
      req_addr_i   <= addr;
      req_len_i    <= vlsu_pkg::vlen_t'(len);
      req_stride_i <= stride;
      req_vew_i    <= vew;
      @(posedge clk_i);
      while (!req_ready_o && timeouts == 0) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("timeout waiting for req_ready_o");
          timeouts++;
        end else begin
          @(posedge clk_i);
        end
      end
      req_valid_i <= 1'b0;
    end
  endtask

  // Until every accepted request is acked and every bus request seen
  task automatic wait_drained();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while ((ack_id_q.size() != 0 || exp_id_q.size() != 0) && timeouts == 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout waiting for outstanding requests to finish");
        timeouts++;
      end else begin
        @(posedge clk_i);
      end
    end
  endtask

  initial begin
    int                waited;
    vlsu_pkg::mem_op_e op;
    vlsu_pkg::vew_e    vew;
    vlsu_pkg::addr_t   addr;
    int                len;
    vlsu_pkg::stride_t stride;
    req_valid_i  = 1'b0;
    req_op_i     = vlsu_pkg::OP_LOAD_UNIT;
    req_addr_i   = '0;
    req_len_i    = '0;
    req_stride_i = '0;
    req_vew_i    = vlsu_pkg::EW8;
    waited = 0;
    while (!rst_ni && timeouts == 0) begin
      waited++;
      if (waited > 100) begin
        $display("timeout waiting for reset release");
        timeouts++;
      end else begin
        @(posedge clk_i);
      end
    end
    if (!req_ready_o || ack_o || error_o || ar_valid_o || aw_valid_o) begin
      report_fault("outputs not idle after reset");
    end
    // Short unit-stride load, one burst
    send_request(vlsu_pkg::OP_LOAD_UNIT, 32'h0000_1000, 5, 0, vlsu_pkg::EW32);
    wait_drained();
    if (beats_seen != 1) report_fault("short unit-stride load did not give one burst");
    // Long store from near a page end, split at the page and at 256 beats
    send_request(vlsu_pkg::OP_STORE_UNIT, 32'h0000_2F80, 600, 0, vlsu_pkg::EW64);
    wait_drained();
    // Strided, upwards and downwards
    beats_seen = 0;
    send_request(vlsu_pkg::OP_LOAD_STRIDED, 32'h0000_0400, 6, 24, vlsu_pkg::EW16);
    send_request(vlsu_pkg::OP_STORE_STRIDED, 32'h0000_8000, 4, -40, vlsu_pkg::EW64);
    wait_drained();
    if (beats_seen != 10) report_fault("strided requests gave the wrong number of beats");
    // Misaligned base, then zero length
    beats_seen = 0;
    send_request(vlsu_pkg::OP_LOAD_UNIT, 32'h0000_1002, 4, 0, vlsu_pkg::EW32);
    send_request(vlsu_pkg::OP_STORE_STRIDED, 32'h0000_3000, 0, 8, vlsu_pkg::EW32);
    wait_drained();
    if (beats_seen != 0) report_fault("rejected or empty request reached the bus");
    // Random requests under ready stalls, mostly back to back
    stall_en <= 1'b1;
    for (int n = 0; n < 40; n++) begin
      op   = vlsu_pkg::mem_op_e'(stim_bits(2));
      vew  = vlsu_pkg::vew_e'(stim_bits(2));
      len  = stim_bits(10) % 701;
      addr = vlsu_pkg::addr_t'(stim_bits(24));
      // Three in four bases aligned
      if (stim_bits(2) != 0) addr = addr & ~vlsu_pkg::addr_t'((1 << vew) - 1);
      stride = vlsu_pkg::stride_t'((int'(stim_bits(7)) - 64) * (1 << vew));
      send_request(op, addr, len, stride, vew);
      if (stim_bits(1) != 0) @(posedge clk_i);
    end
    wait_drained();
    $display("value errors %0d, protocol errors %0d, timeouts %0d",
             value_errors, order_errors, timeouts);
    if (value_errors == 0 && order_errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sim/tb_clk_gen.sv
// Clock and reset source of the address generator testbench, instantiated by its top module
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held low for the first 8 rising edges
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- rtl/addrgen_top.sv
// Top level of the vector address generator, joining the request checker and the burst splitter
`timescale 1ns/1ns

module addrgen_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Vector memory requests
  input  logic                   req_valid_i,
  input  vlsu_pkg::mem_op_e      req_op_i,
  input  vlsu_pkg::addr_t        req_addr_i,
  input  vlsu_pkg::vlen_t        req_len_i,
  input  vlsu_pkg::stride_t      req_stride_i,
  input  vlsu_pkg::vew_e         req_vew_i,
  output logic                   req_ready_o,
  output logic                   ack_o,
  output logic                   error_o,
  // Read address channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output vlsu_pkg::addr_t        ar_addr_o,
  output axi_addr_pkg::ax_len_t  ar_len_o,
  output axi_addr_pkg::ax_size_t ar_size_o,
  // Write address channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output vlsu_pkg::addr_t        aw_addr_o,
  output axi_addr_pkg::ax_len_t  aw_len_o,
  output axi_addr_pkg::ax_size_t aw_size_o
);

  // Stage one to stage two
  logic              cmd_valid;
  logic              cmd_ready;
  logic              cmd_done;
  vlsu_pkg::mem_op_e cmd_op;
  vlsu_pkg::addr_t   cmd_addr;
  vlsu_pkg::vlen_t   cmd_len;
  vlsu_pkg::stride_t cmd_stride;
  vlsu_pkg::vew_e    cmd_vew;

  addrgen_req_check u_req_check (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_len_i    (req_len_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .req_ready_o  (req_ready_o),
    .cmd_valid_o  (cmd_valid),
    .cmd_op_o     (cmd_op),
    .cmd_addr_o   (cmd_addr),
    .cmd_len_o    (cmd_len),
    .cmd_stride_o (cmd_stride),
    .cmd_vew_o    (cmd_vew),
    .cmd_ready_i  (cmd_ready),
    .cmd_done_i   (cmd_done),
    .ack_o        (ack_o),
    .error_o      (error_o)
  );

  addrgen_burst_split u_burst_split (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid),
    .cmd_op_i     (cmd_op),
    .cmd_addr_i   (cmd_addr),
    .cmd_len_i    (cmd_len),
    .cmd_stride_i (cmd_stride),
    .cmd_vew_i    (cmd_vew),
    .cmd_ready_o  (cmd_ready),
    .cmd_done_o   (cmd_done),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_addr_o    (ar_addr_o),
    .ar_len_o     (ar_len_o),
    .ar_size_o    (ar_size_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .aw_addr_o    (aw_addr_o),
    .aw_len_o     (aw_len_o),
    .aw_size_o    (aw_size_o)
  );

endmodule

//--- rtl/addrgen_burst_split.sv
// Pipeline stage two that the top level uses to split held commands into AR or AW requests
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module addrgen_burst_split (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Command from stage one
  input  logic                   cmd_valid_i,
  input  vlsu_pkg::mem_op_e      cmd_op_i,
  input  vlsu_pkg::addr_t        cmd_addr_i,
  input  vlsu_pkg::vlen_t        cmd_len_i,
  input  vlsu_pkg::stride_t      cmd_stride_i,
  input  vlsu_pkg::vew_e         cmd_vew_i,
  output logic                   cmd_ready_o,
  output logic                   cmd_done_o,
  // Read address channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output vlsu_pkg::addr_t        ar_addr_o,
  output axi_addr_pkg::ax_len_t  ar_len_o,
  output axi_addr_pkg::ax_size_t ar_size_o,
  // Write address channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output vlsu_pkg::addr_t        aw_addr_o,
  output axi_addr_pkg::ax_len_t  aw_len_o,
  output axi_addr_pkg::ax_size_t aw_size_o
);

  // Last byte of the next unit-stride burst
  // Earliest of transfer end, burst length limit and page end
  function automatic vlsu_pkg::addr_t burst_end(
    vlsu_pkg::addr_t addr,
    vlsu_pkg::vlen_t rem,
    vlsu_pkg::vew_e  vew
  );
    vlsu_pkg::addr_t xfer_end;
    vlsu_pkg::addr_t word_addr;
    vlsu_pkg::addr_t beat_end;
    vlsu_pkg::addr_t page_end;
    vlsu_pkg::addr_t last;
    xfer_end  = addr + (vlsu_pkg::addr_t'(rem) << vew) - vlsu_pkg::addr_t'(1);
    word_addr = addr & ~vlsu_pkg::addr_t'(`DATA_BYTES - 1);
    beat_end  = word_addr + vlsu_pkg::addr_t'(`MAX_BURST_BEATS << `DATA_BYTES_LOG)
              - vlsu_pkg::addr_t'(1);
    page_end  = addr | vlsu_pkg::addr_t'((1 << `PAGE_BITS) - 1);
    last = xfer_end;
    if (beat_end < last) begin
      last = beat_end;
    end
    if (page_end < last) begin
      last = page_end;
    end
    return last;
  endfunction

  typedef enum logic [1:0] {
    IDLE,
    PLAN,
    REQUEST
  } state_e;

  state_e            state_q;
  state_e            state_d;

  // Current command
  vlsu_pkg::mem_op_e op_q;
  vlsu_pkg::stride_t stride_q;
  vlsu_pkg::vew_e    vew_q;
  vlsu_pkg::addr_t   addr_q;
  vlsu_pkg::addr_t   addr_d;
  vlsu_pkg::vlen_t   rem_q;
  vlsu_pkg::vlen_t   rem_d;
  vlsu_pkg::addr_t   end_q;
  vlsu_pkg::addr_t   end_d;

  logic                   is_load;
  logic                   is_unit;
  logic                   req_valid;
  logic                   ax_ready;
  logic                   xfer;
  vlsu_pkg::addr_t        next_word_addr;
  vlsu_pkg::addr_t        bytes_covered;
  vlsu_pkg::vlen_t        elems_covered;
  vlsu_pkg::vlen_t        unit_rem;
  axi_addr_pkg::ax_len_t  beat_len;
  axi_addr_pkg::ax_size_t beat_size;

  assign is_load = vlsu_pkg::is_load_op(op_q);
  assign is_unit = vlsu_pkg::is_unit_op(op_q);

  ////////////////////
  // Burst datapath
  ////////////////////

  // Next burst starts on the bus word after this one
  assign next_word_addr = ((end_q >> `DATA_BYTES_LOG) + vlsu_pkg::addr_t'(1))
                        << `DATA_BYTES_LOG;
  assign bytes_covered  = end_q - addr_q + vlsu_pkg::addr_t'(1);
  assign elems_covered  = vlsu_pkg::vlen_t'(bytes_covered >> vew_q);
  // Floor at zero
  assign unit_rem = (rem_q > elems_covered) ? (rem_q - elems_covered) : '0;

  // Strided beats are single elements
  assign beat_len  = is_unit ? axi_addr_pkg::burst_len(addr_q, end_q) : '0;
  assign beat_size = is_unit ? axi_addr_pkg::AX_SIZE_FULL
                             : axi_addr_pkg::ax_size_t'(vew_q);

  ////////////////////
  // Channel drive
  ////////////////////

  assign req_valid = (state_q == REQUEST);
  assign ax_ready  = is_load ? ar_ready_i : aw_ready_i;
  assign xfer      = req_valid && ax_ready;

  // Loads go to AR and stores to AW
  assign ar_valid_o = req_valid && is_load;
  assign aw_valid_o = req_valid && !is_load;

  assign ar_addr_o = addr_q;
  assign ar_len_o  = beat_len;
  assign ar_size_o = beat_size;
  assign aw_addr_o = addr_q;
  assign aw_len_o  = beat_len;
  assign aw_size_o = beat_size;

  assign cmd_ready_o = (state_q == IDLE);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d    = state_q;
    addr_d     = addr_q;
    rem_d      = rem_q;
    end_d      = end_q;
    cmd_done_o = 1'b0;
    case (state_q)
      IDLE: begin
        // Load a new command
        addr_d = cmd_addr_i;
        rem_d  = cmd_len_i;
        if (cmd_valid_i) begin
          state_d = PLAN;
        end
      end
      PLAN: begin
        // First burst boundary
        end_d   = burst_end(addr_q, rem_q, vew_q);
        state_d = REQUEST;
      end
      REQUEST: begin
        if (xfer) begin
          if (is_unit) begin
            addr_d = next_word_addr;
            rem_d  = unit_rem;
            // Following burst boundary ready back to back
            end_d  = burst_end(addr_d, rem_d, vew_q);
          end else begin
            addr_d = addr_q + vlsu_pkg::addr_t'(stride_q);
            rem_d  = rem_q - vlsu_pkg::vlen_t'(1);
          end
          // Last bus request of the command
          if (rem_d == '0) begin
            cmd_done_o = 1'b1;
            state_d    = IDLE;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    rem_q  <= rem_d;
    end_q  <= end_d;
    if (cmd_valid_i && cmd_ready_o) begin
      op_q     <= cmd_op_i;
      stride_q <= cmd_stride_i;
      vew_q    <= cmd_vew_i;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Held request keeps its payload until taken
  ar_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable({ar_addr_o, ar_len_o, ar_size_o}));

  aw_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable({aw_addr_o, aw_len_o, aw_size_o}));

endmodule

//--- rtl/addrgen_req_check.sv
// Stage one of the address generator: holds a request, checks alignment, forwards it or retires it
`timescale 1ns/1ns

module addrgen_req_check (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Request side
  input  logic              req_valid_i,
  input  vlsu_pkg::mem_op_e req_op_i,
  input  vlsu_pkg::addr_t   req_addr_i,
  input  vlsu_pkg::vlen_t   req_len_i,
  input  vlsu_pkg::stride_t req_stride_i,
  input  vlsu_pkg::vew_e    req_vew_i,
  output logic              req_ready_o,
  // Command to stage two
  output logic              cmd_valid_o,
  output vlsu_pkg::mem_op_e cmd_op_o,
  output vlsu_pkg::addr_t   cmd_addr_o,
  output vlsu_pkg::vlen_t   cmd_len_o,
  output vlsu_pkg::stride_t cmd_stride_o,
  output vlsu_pkg::vew_e    cmd_vew_o,
  input  logic              cmd_ready_i,
  input  logic              cmd_done_i,
  // Acknowledge
  output logic              ack_o,
  output logic              error_o
);

  logic       hold_q;
  logic       done_pend_q;
  logic [1:0] inflight_q;
  logic       accept;
  logic       bad_addr;
  logic       empty_req;
  logic       retire_direct;
  logic       handover;

  // Held request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_op_o     <= req_op_i;
      cmd_addr_o   <= req_addr_i;
      cmd_len_o    <= req_len_i;
      cmd_stride_o <= req_stride_i;
      cmd_vew_o    <= req_vew_i;
    end
  end

  // Take a new request only into an empty holder
  assign req_ready_o = !hold_q;
  assign accept      = req_valid_i && req_ready_o;

  assign bad_addr  = vlsu_pkg::is_misaligned(cmd_addr_o, cmd_vew_o);
  assign empty_req = (cmd_len_o == '0);

  // Retire here only once stage two is idle and its ack is out
  // This keeps acks in acceptance order
  assign retire_direct = hold_q && (bad_addr || empty_req) && cmd_ready_i
                      && !cmd_done_i && !done_pend_q;

  assign cmd_valid_o = hold_q && !bad_addr && !empty_req;
  assign handover    = cmd_valid_o && cmd_ready_i;

  // Done ack arrives one cycle late, never together with a direct one
  assign ack_o   = done_pend_q || retire_direct;
  assign error_o = retire_direct && bad_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q      <= 1'b0;
      done_pend_q <= 1'b0;
      inflight_q  <= '0;
    end else begin
      done_pend_q <= cmd_done_i;
      if (accept) begin
        hold_q <= 1'b1;
      end else if (retire_direct || handover) begin
        hold_q <= 1'b0;
      end
      // Requests accepted but not yet acked
      if (accept && !ack_o) begin
        inflight_q <= inflight_q + 2'd1;
      end else if (!accept && ack_o) begin
        inflight_q <= inflight_q - 2'd1;
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Every ack belongs to an earlier acceptance
  ack_owner_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> (inflight_q != '0));

endmodule

//--- rtl/axi_addr_pkg.sv
// Field types of the AR/AW address channels, referenced by scoped name from the burst splitter
`include "addrgen_defs.svh"

package axi_addr_pkg;

  // Beats minus one
  typedef logic [7:0] ax_len_t;

  // log2 of the bytes per beat
  typedef logic [2:0] ax_size_t;

  // Full bus width beat, used by every unit-stride burst
  localparam ax_size_t AX_SIZE_FULL = ax_size_t'(`DATA_BYTES_LOG);

  // Len field of a burst from its first to its last byte
  // Both bytes must lie within MAX_BURST_BEATS bus words
  function automatic ax_len_t burst_len(
    logic [`ADDR_W-1:0] first_byte,
    logic [`ADDR_W-1:0] last_byte
  );
    logic [`ADDR_W-1:0] first_word;
    logic [`ADDR_W-1:0] last_word;
    first_word = first_byte >> `DATA_BYTES_LOG;
    last_word  = last_byte >> `DATA_BYTES_LOG;
    // Bus words touched, minus one
    return ax_len_t'(last_word - first_word);
  endfunction

endpackage

//--- rtl/vlsu_pkg.sv
// Types and helpers for vector memory requests, referenced by scoped name from the address generator
`include "addrgen_defs.svh"

package vlsu_pkg;

  // Element width, value is log2 of the bytes per element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Bit 1 selects store, bit 0 selects strided
  typedef enum logic [1:0] {
    OP_LOAD_UNIT     = 2'b00,
    OP_LOAD_STRIDED  = 2'b01,
    OP_STORE_UNIT    = 2'b10,
    OP_STORE_STRIDED = 2'b11
  } mem_op_e;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`LEN_W-1:0] vlen_t;
  // Byte stride, negative values walk downwards
  typedef logic signed [`ADDR_W-1:0] stride_t;

  function automatic logic is_load_op(mem_op_e op);
    return op inside {OP_LOAD_UNIT, OP_LOAD_STRIDED};
  endfunction

  function automatic logic is_unit_op(mem_op_e op);
    return op inside {OP_LOAD_UNIT, OP_STORE_UNIT};
  endfunction

  // Any low address bit set below the element size
  function automatic logic is_misaligned(addr_t addr, vew_e vew);
    return |(addr & ((addr_t'(1) << vew) - addr_t'(1)));
  endfunction

endpackage

//--- rtl/addrgen_defs.svh
// Widths and bus limits of the vector address generator, included by its packages and RTL
`ifndef ADDRGEN_DEFS_SVH
`define ADDRGEN_DEFS_SVH

// Byte address width
`define ADDR_W 32

// Element count width of one vector request
`define LEN_W 16

// Data bus width in bytes and its base-two log
`define DATA_BYTES 8
`define DATA_BYTES_LOG 3

// Longest incrementing burst on the bus
`define MAX_BURST_BEATS 256

// Bursts never cross a page of 2**PAGE_BITS bytes
`define PAGE_BITS 12

`endif
